// ==== rtl/dom_params.svh ====
`ifndef DOM_PARAMS_SVH
`define DOM_PARAMS_SVH

// Datapath size
`define DOM_LANES       4
`define DOM_SHARES      3

// Randomness source, Galois LFSR
`define DOM_LFSR_W      32
`define DOM_LFSR_SEED   32'hB4E1_7A35

// APB register map, byte offsets
`define DOM_ADDR_W      5
`define DOM_REG_OPA     5'h00
`define DOM_REG_OPB     5'h04
`define DOM_REG_CTRL    5'h08
`define DOM_REG_STATUS  5'h0C
`define DOM_REG_RESULT  5'h10

`endif

// ==== rtl/dom_pkg.sv ====
`include "dom_params.svh"

package dom_pkg;

    // One share pair per unordered domain pair
    localparam int NumPairs = `DOM_SHARES * (`DOM_SHARES - 1) / 2;

    typedef logic [1:0] gf4_t;
    typedef gf4_t [`DOM_LANES-1:0] opWord_t;
    typedef gf4_t [`DOM_SHARES-1:0] sharedGf4_t;
    typedef gf4_t [NumPairs-1:0] freshRand_t;

    typedef struct packed {
        logic       valid;
        sharedGf4_t x;
        sharedGf4_t y;
        freshRand_t z;
    } laneIn_t;

    typedef struct packed {
        logic       valid;
        sharedGf4_t q;
    } laneOut_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`DOM_ADDR_W-1:0] paddr;
        logic [31:0]            pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRsp_t;

    // GF(2^2) product, polynomial basis, x^2+x+1
    function automatic gf4_t gf4Mul(gf4_t a, gf4_t b);
        gf4_t c;
        c[1] = (a[1] & b[1]) ^ (a[1] & b[0]) ^ (a[0] & b[1]);
        c[0] = (a[1] & b[1]) ^ (a[0] & b[0]);
        return c;
    endfunction

    // Index of the randomness slot shared by domains i and j
    function automatic int pairIndex(int i, int j);
        int lo;
        int hi;
        lo = (i < j) ? i : j;
        hi = (i < j) ? j : i;
        return lo * (2 * `DOM_SHARES - lo - 1) / 2 + (hi - lo - 1);
    endfunction

endpackage

// ==== rtl/dom_apb_regs.sv ====
`timescale 1ns/1ns
`include "dom_params.svh"

module dom_apb_regs (
    input  logic             ClkxCI,
    input  logic             rstN,
    input  dom_pkg::apbReq_t apbReq,
    output dom_pkg::apbRsp_t apbRsp,
    output logic             opStart,
    output dom_pkg::opWord_t opA,
    output dom_pkg::opWord_t opB,
    input  logic             resValid,
    input  dom_pkg::opWord_t result
);
    import dom_pkg::*;

    localparam int OpBits = $bits(opWord_t);

    opWord_t resultReg;
    logic    busy;
    logic    done;

    logic access;
    logic hitOpA;
    logic hitOpB;
    logic hitCtrl;
    logic hitStatus;
    logic hitResult;
    logic mapped;
    logic wrBlocked;
    logic wrReadOnly;
    logic wrEn;

    // Address decode
    assign hitOpA    = (apbReq.paddr == `DOM_REG_OPA);
    assign hitOpB    = (apbReq.paddr == `DOM_REG_OPB);
    assign hitCtrl   = (apbReq.paddr == `DOM_REG_CTRL);
    assign hitStatus = (apbReq.paddr == `DOM_REG_STATUS);
    assign hitResult = (apbReq.paddr == `DOM_REG_RESULT);
    assign mapped    = hitOpA | hitOpB | hitCtrl | hitStatus | hitResult;

    // Access phase of a transfer, never stretched
    assign access = apbReq.psel & apbReq.penable;

    // Writable registers are locked while an operation is running
    assign wrBlocked  = busy & (hitOpA | hitOpB | hitCtrl);
    assign wrReadOnly = hitStatus | hitResult;
    assign wrEn       = access & apbReq.pwrite & ~busy;

    assign opStart = wrEn & hitCtrl & apbReq.pwdata[0];

    assign apbRsp.pready  = 1'b1;
    assign apbRsp.pslverr = access & (~mapped | (apbReq.pwrite & (wrBlocked | wrReadOnly)));

    always_comb begin
        apbRsp.prdata = '0;
        case (apbReq.paddr)
            `DOM_REG_OPA:    apbRsp.prdata = 32'(opA);
            `DOM_REG_OPB:    apbRsp.prdata = 32'(opB);
            `DOM_REG_STATUS: apbRsp.prdata = {30'b0, done, busy};
            `DOM_REG_RESULT: apbRsp.prdata = 32'(resultReg);
            // CTRL start bit is self clearing and reads back as zero
            default:         apbRsp.prdata = '0;
        endcase
    end

    always_ff @(posedge ClkxCI) begin
        if (!rstN) begin
            opA       <= '0;
            opB       <= '0;
            resultReg <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            if (wrEn && hitOpA) begin
                opA <= apbReq.pwdata[OpBits-1:0];
            end
            if (wrEn && hitOpB) begin
                opB <= apbReq.pwdata[OpBits-1:0];
            end

            if (opStart) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (busy && resValid) begin
                // Product arrives three cycles after start
                busy      <= 1'b0;
                done      <= 1'b1;
                resultReg <= result;
            end
        end
    end

endmodule

// ==== rtl/share_splitter.sv ====
`timescale 1ns/1ns
`include "dom_params.svh"

module share_splitter (
    input  logic             ClkxCI,
    input  logic             rstN,
    input  logic             opStart,
    input  dom_pkg::opWord_t opA,
    input  dom_pkg::opWord_t opB,
    output dom_pkg::laneIn_t laneIn [`DOM_LANES]
);
    import dom_pkg::*;

    // Per lane random bits hold x masks, y masks and z
    localparam int MaskBits = 2 * (`DOM_SHARES - 1);
    localparam int ZBits    = $bits(freshRand_t);
    localparam int LaneBits = 2 * MaskBits + ZBits;
    localparam int RandBits = `DOM_LANES * LaneBits;

    // x^32 + x^22 + x^2 + x + 1
    localparam logic [`DOM_LFSR_W-1:0] Taps = 32'h8020_0003;

    logic [`DOM_LFSR_W-1:0] lfsrQ;
    logic [`DOM_LFSR_W-1:0] lfsrNext;
    logic [RandBits-1:0]    randBits;

    function automatic sharedGf4_t maskElem(gf4_t e, logic [MaskBits-1:0] r);
        sharedGf4_t s;
        s[0] = e;
        for (int i = 1; i < `DOM_SHARES; i++) begin
            s[i] = r[2*(i-1) +: 2];
            s[0] = s[0] ^ s[i];
        end
        return s;
    endfunction

    // Leap the LFSR by RandBits shifts, one output bit per shift
    always_comb begin
        lfsrNext = lfsrQ;
        for (int k = 0; k < RandBits; k++) begin
            randBits[k] = lfsrNext[0];
            lfsrNext    = lfsrNext[0] ? ((lfsrNext >> 1) ^ Taps) : (lfsrNext >> 1);
        end
    end

    always_ff @(posedge ClkxCI) begin
        if (!rstN) begin
            lfsrQ <= `DOM_LFSR_SEED;
            for (int l = 0; l < `DOM_LANES; l++) begin
                laneIn[l].valid <= 1'b0;
            end
        end else begin
            for (int l = 0; l < `DOM_LANES; l++) begin
                laneIn[l].valid <= opStart;
            end
            if (opStart) begin
                lfsrQ <= lfsrNext;
                // Share payload, each lane gets its own slice of fresh bits
                for (int l = 0; l < `DOM_LANES; l++) begin
                    laneIn[l].x <= maskElem(opA[l], randBits[l*LaneBits +: MaskBits]);
                    laneIn[l].y <= maskElem(opB[l], randBits[l*LaneBits + MaskBits +: MaskBits]);
                    laneIn[l].z <= randBits[l*LaneBits + 2*MaskBits +: ZBits];
                end
            end
        end
    end

endmodule

// ==== rtl/dom_mul_gf4.sv ====
`timescale 1ns/1ns
`include "dom_params.svh"

module dom_mul_gf4 (
    input  logic              ClkxCI,
    input  logic              rstN,
    input  dom_pkg::laneIn_t  laneIn,
    output dom_pkg::laneOut_t laneOut
);
    import dom_pkg::*;

    // Row i holds the products x[i]*y[j] for every domain j
    sharedGf4_t [`DOM_SHARES-1:0] termD;
    sharedGf4_t [`DOM_SHARES-1:0] termQ;
    sharedGf4_t                   qComp;
    logic                         validQ;

    // Multiplication layer
    always_comb begin
        for (int i = 0; i < `DOM_SHARES; i++) begin
            for (int j = 0; j < `DOM_SHARES; j++) begin
                termD[i][j] = gf4Mul(laneIn.x[i], laneIn.y[j]);
                // Cross-domain terms are remasked before the register
                if (i != j) begin
                    termD[i][j] = termD[i][j] ^ laneIn.z[pairIndex(i, j)];
                end
            end
        end
    end

    // Resharing register, this stage breaks the glitch paths between domains
    always_ff @(posedge ClkxCI) begin
        if (laneIn.valid) begin
            termQ <= termD;
        end
    end

    always_ff @(posedge ClkxCI) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= laneIn.valid;
        end
    end

    // Integration layer
    always_comb begin
        for (int i = 0; i < `DOM_SHARES; i++) begin
            qComp[i] = '0;
            for (int j = 0; j < `DOM_SHARES; j++) begin
                qComp[i] = qComp[i] ^ termQ[i][j];
            end
        end
    end

    assign laneOut.valid = validQ;
    assign laneOut.q     = qComp;

endmodule

// ==== rtl/share_combiner.sv ====
`timescale 1ns/1ns
`include "dom_params.svh"

module share_combiner (
    input  logic              ClkxCI,
    input  logic              rstN,
    input  dom_pkg::laneOut_t laneOut [`DOM_LANES],
    output logic              resValid,
    output dom_pkg::opWord_t  result
);
    import dom_pkg::*;

    logic [`DOM_LANES-1:0] laneValid;
    logic                  allValid;

    function automatic gf4_t unmask(sharedGf4_t s);
        gf4_t v;
        v = '0;
        for (int i = 0; i < `DOM_SHARES; i++) begin
            v = v ^ s[i];
        end
        return v;
    endfunction

    // Lanes run in lockstep
    always_comb begin
        for (int l = 0; l < `DOM_LANES; l++) begin
            laneValid[l] = laneOut[l].valid;
        end
    end

    assign allValid = &laneValid;

    always_ff @(posedge ClkxCI) begin
        if (allValid) begin
            for (int l = 0; l < `DOM_LANES; l++) begin
                result[l] <= unmask(laneOut[l].q);
            end
        end
    end

    always_ff @(posedge ClkxCI) begin
        if (!rstN) begin
            resValid <= 1'b0;
        end else begin
            resValid <= allValid;
        end
    end

endmodule

// ==== rtl/dom_gf4_top.sv ====
`timescale 1ns/1ns
`include "dom_params.svh"

module dom_gf4_top (
    input  logic             ClkxCI,
    input  logic             rstN,
    input  dom_pkg::apbReq_t apbReq,
    output dom_pkg::apbRsp_t apbRsp
);
    import dom_pkg::*;

    logic     opStart;
    opWord_t  opA;
    opWord_t  opB;
    opWord_t  result;
    logic     resValid;
    laneIn_t  laneIn [`DOM_LANES];
    laneOut_t laneOut [`DOM_LANES];

    dom_apb_regs uRegs (
        .ClkxCI   (ClkxCI),
        .rstN     (rstN),
        .apbReq   (apbReq),
        .apbRsp   (apbRsp),
        .opStart  (opStart),
        .opA      (opA),
        .opB      (opB),
        .resValid (resValid),
        .result   (result)
    );

    share_splitter uSplitter (
        .ClkxCI  (ClkxCI),
        .rstN    (rstN),
        .opStart (opStart),
        .opA     (opA),
        .opB     (opB),
        .laneIn  (laneIn)
    );

    // One masked multiplier per element position
    for (genvar l = 0; l < `DOM_LANES; l++) begin : gLane
        dom_mul_gf4 uLane (
            .ClkxCI  (ClkxCI),
            .rstN    (rstN),
            .laneIn  (laneIn[l]),
            .laneOut (laneOut[l])
        );
    end

    share_combiner uCombiner (
        .ClkxCI   (ClkxCI),
        .rstN     (rstN),
        .laneOut  (laneOut),
        .resValid (resValid),
        .result   (result)
    );

endmodule

// ==== sim/dom_gf4_checker.sv ====
`timescale 1ns/1ns

module dom_gf4_checker (
    input logic ClkxCI,
    input logic rstN,
    input logic inValid,
    input logic outValid,
    input logic psel,
    input logic penable,
    input logic pslverr,
    input logic pready
);
    int failCount = 0;

    // Lane output follows its input by exactly one cycle
    aOutAfterIn: assert property (@(posedge ClkxCI) disable iff (!rstN) inValid |=> outValid)
        else begin
            $error("lane output valid missing one cycle after input valid");
            failCount++;
        end

    aOutNotEarly: assert property (@(posedge ClkxCI) disable iff (!rstN)
                                   outValid |-> $past(inValid))
        else begin
            $error("lane output valid without input valid one cycle before");
            failCount++;
        end

    aErrInAccess: assert property (@(posedge ClkxCI) disable iff (!rstN)
                                   pslverr |-> (psel && penable))
        else begin
            $error("pslverr raised outside an APB access cycle");
            failCount++;
        end

    // No wait states on this bus
    aReadyInAccess: assert property (@(posedge ClkxCI) disable iff (!rstN)
                                     (psel && penable) |-> pready)
        else begin
            $error("pready low in an APB access cycle");
            failCount++;
        end

endmodule

bind dom_mul_gf4 dom_gf4_checker uLaneChk (
    .ClkxCI   (ClkxCI),
    .rstN     (rstN),
    .inValid  (laneIn.valid),
    .outValid (laneOut.valid),
    .psel     (1'b0),
    .penable  (1'b0),
    .pslverr  (1'b0),
    .pready   (1'b0)
);

bind dom_apb_regs dom_gf4_checker uApbChk (
    .ClkxCI   (ClkxCI),
    .rstN     (rstN),
    .inValid  (1'b0),
    .outValid (1'b0),
    .psel     (apbReq.psel),
    .penable  (apbReq.penable),
    .pslverr  (apbRsp.pslverr),
    .pready   (apbRsp.pready)
);

// ==== sim/dom_gf4_monitor.sv ====
`timescale 1ns/1ns
`include "dom_params.svh"

module dom_gf4_monitor (
    input logic             ClkxCI,
    input logic             rstN,
    input dom_pkg::apbReq_t apbReq,
    input dom_pkg::apbRsp_t apbRsp
);
    import dom_pkg::*;

    localparam int OpBits = $bits(opWord_t);

    string   testName   = "reset";
    opWord_t expResult  = '0;
    logic    expValid   = 1'b0;
    int      errCount   = 0;
    int      checkCount = 0;

    opWord_t mirA;
    opWord_t mirB;
    opWord_t modelResult;

    // Field rule for x^2+x+1 in polynomial basis
    // Carry-less product, then reduce with x^2 = x + 1
    function automatic gf4_t fieldProduct(gf4_t a, gf4_t b);
        logic [2:0] p;
        p = '0;
        for (int i = 0; i < 2; i++) begin
            if (b[i]) begin
                p = p ^ (3'(a) << i);
            end
        end
        return p[1:0] ^ {2{p[2]}};
    endfunction

    function automatic opWord_t wordProduct(opWord_t a, opWord_t b);
        opWord_t c;
        for (int l = 0; l < `DOM_LANES; l++) begin
            c[l] = fieldProduct(a[l], b[l]);
        end
        return c;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        checkCount++;
        if (act !== exp) begin
            errCount++;
            $display("ERR %s expected %h actual %h", what, exp, act);
        end
    endtask

    task automatic noteFailure(input string what);
        errCount++;
        $display("FAILURE %s", what);
    endtask

    // Access cycles sampled mid-cycle while the bus is stable
    always @(negedge ClkxCI) begin
        if (!rstN) begin
            mirA        = '0;
            mirB        = '0;
            modelResult = '0;
        end else if (apbReq.psel && apbReq.penable) begin
            if (apbReq.pwrite && !apbRsp.pslverr) begin
                case (apbReq.paddr)
                    `DOM_REG_OPA:  mirA = apbReq.pwdata[OpBits-1:0];
                    `DOM_REG_OPB:  mirB = apbReq.pwdata[OpBits-1:0];
                    `DOM_REG_CTRL: begin
                        if (apbReq.pwdata[0]) begin
                            modelResult = wordProduct(mirA, mirB);
                        end
                    end
                    default: ;
                endcase
            end else if (!apbReq.pwrite && apbReq.paddr == `DOM_REG_RESULT) begin
                checkValue({testName, " result"}, 32'(modelResult), apbRsp.prdata);
                if (expValid) begin
                    checkValue({testName, " table"}, 32'(expResult), apbRsp.prdata);
                end
            end
        end
    end

endmodule

// ==== sim/dom_gf4_tb.sv ====
`timescale 1ns/1ns
`include "dom_params.svh"

module dom_gf4_tb;
    import dom_pkg::*;

    localparam int DriveDelay     = 10;
    localparam int PollCycles     = 50;
    localparam int TransferCycles = 3;
    localparam int NumFixed       = 6;
    localparam int NumRows        = NumFixed + 20;

    typedef struct packed {
        opWord_t opA;
        opWord_t opB;
        opWord_t expRes;
        logic    hasExp;
    } stimRow_t;

    logic    ClkxCI;
    logic    rstN;
    apbReq_t apbReq;
    apbRsp_t apbRsp;

    stimRow_t rows [NumRows];
    string    rowNames [NumRows];
    int       laneFails [`DOM_LANES];

    dom_gf4_top uut (
        .ClkxCI (ClkxCI),
        .rstN   (rstN),
        .apbReq (apbReq),
        .apbRsp (apbRsp)
    );

    dom_gf4_monitor mon (
        .ClkxCI (ClkxCI),
        .rstN   (rstN),
        .apbReq (apbReq),
        .apbRsp (apbRsp)
    );

    // Assertion failures of the checker in each lane
    for (genvar l = 0; l < `DOM_LANES; l++) begin : gLaneFails
        assign laneFails[l] = uut.gLane[l].uLane.uLaneChk.failCount;
    end

    initial begin
        ClkxCI = 1'b0;
        forever #50 ClkxCI = ~ClkxCI;
    end

    // Setup cycle, access cycle, then back to idle
    task automatic apbTransfer(input logic wr, input logic [`DOM_ADDR_W-1:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
        @(posedge ClkxCI);
        #DriveDelay;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = wr;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        @(posedge ClkxCI);
        #DriveDelay;
        apbReq.penable = 1'b1;
        @(negedge ClkxCI);
        rdata = apbRsp.prdata;
        err   = apbRsp.pslverr;
        @(posedge ClkxCI);
        #DriveDelay;
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
    endtask

    task automatic apbWrite(input string what, input logic [`DOM_ADDR_W-1:0] addr,
                            input logic [31:0] data, input logic expErr);
        logic [31:0] rdata;
        logic        err;
        apbTransfer(1'b1, addr, data, rdata, err);
        mon.checkValue({what, " pslverr"}, 32'(expErr), 32'(err));
    endtask

    task automatic apbRead(input string what, input logic [`DOM_ADDR_W-1:0] addr,
                           output logic [31:0] data);
        logic err;
        apbTransfer(1'b0, addr, 32'h0, data, err);
        mon.checkValue({what, " read pslverr"}, 32'h0, 32'(err));
    endtask

    task automatic waitDone(input string what);
        logic [31:0] status;
        logic        seen;
        seen = 1'b0;
        for (int cyc = 0; cyc < PollCycles && !seen; cyc += TransferCycles) begin
            apbRead(what, `DOM_REG_STATUS, status);
            seen = (status[1:0] == 2'b10);
        end
        if (!seen) begin
            mon.noteFailure({what, " timed out waiting for done in STATUS"});
        end
    endtask

    // Monitor compares the RESULT read against its model and the table
    task automatic readResult(input string what, input logic hasExp, input opWord_t expRes);
        logic [31:0] data;
        mon.testName  = what;
        mon.expResult = expRes;
        mon.expValid  = hasExp;
        apbRead(what, `DOM_REG_RESULT, data);
        mon.expValid  = 1'b0;
    endtask

    task automatic runRow(input string what, input stimRow_t row);
        logic [31:0] status;
        mon.testName = what;
        apbWrite(what, `DOM_REG_OPA, 32'(row.opA), 1'b0);
        apbWrite(what, `DOM_REG_OPB, 32'(row.opB), 1'b0);
        apbWrite(what, `DOM_REG_CTRL, 32'h1, 1'b0);
        // Busy set and done cleared by the start
        apbRead(what, `DOM_REG_STATUS, status);
        mon.checkValue({what, " status after start"}, 32'h1, status);
        waitDone(what);
        readResult(what, row.hasExp, row.expRes);
    endtask

    task automatic checkErrorResponses();
        logic [31:0] data;
        mon.testName = "busy_write";
        apbWrite("busy_write", `DOM_REG_OPA, 32'h1B, 1'b0);
        apbWrite("busy_write", `DOM_REG_OPB, 32'h2D, 1'b0);
        apbWrite("busy_write", `DOM_REG_CTRL, 32'h1, 1'b0);
        apbWrite("busy_write opa", `DOM_REG_OPA, 32'hFF, 1'b1);
        waitDone("busy_write");
        readResult("busy_write", 1'b1, 8'h27);
        apbWrite("result_write", `DOM_REG_RESULT, 32'h55, 1'b1);
        readResult("result_write", 1'b1, 8'h27);
        apbWrite("unmapped_write", 5'h14, 32'hFF, 1'b1);
        apbRead("unmapped_write", `DOM_REG_OPA, data);
        mon.checkValue("unmapped_write opa", 32'h1B, data);
        apbRead("unmapped_write", `DOM_REG_OPB, data);
        mon.checkValue("unmapped_write opb", 32'h2D, data);
    endtask

    task automatic setRow(input int idx, input string name, input opWord_t a,
                          input opWord_t b, input opWord_t e);
        rows[idx].opA    = a;
        rows[idx].opB    = b;
        rows[idx].expRes = e;
        rows[idx].hasExp = 1'b1;
        rowNames[idx]    = name;
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] rnd;
        int          asrtFails;
        void'($urandom(79022));
        rstN   = 1'b0;
        apbReq = '0;

        // All 16 element pairs, rotated through the lanes
        setRow(0, "field_row0", 8'hE4, 8'hE4, 8'hB4);
        setRow(1, "field_row1", 8'h39, 8'h4E, 8'h06);
        setRow(2, "field_row2", 8'h4E, 8'hE4, 8'hCC);
        setRow(3, "field_row3", 8'h93, 8'h4E, 8'h81);
        setRow(4, "all_three", 8'hFF, 8'hFF, 8'hAA);
        setRow(5, "one_times_x", 8'h55, 8'hAA, 8'hAA);
        for (int r = NumFixed; r < NumRows; r++) begin
            rnd            = $urandom;
            rows[r].opA    = rnd[$bits(opWord_t)-1:0];
            rnd            = $urandom;
            rows[r].opB    = rnd[$bits(opWord_t)-1:0];
            rows[r].expRes = '0;
            rows[r].hasExp = 1'b0;
            rowNames[r]    = $sformatf("random_%0d", r - NumFixed);
        end

        repeat (2) @(posedge ClkxCI);
        #DriveDelay;
        rstN = 1'b1;

        mon.testName = "reset";
        apbRead("reset", `DOM_REG_STATUS, data);
        mon.checkValue("reset status", 32'h0, data);
        readResult("reset", 1'b1, '0);

        for (int r = 0; r < NumRows; r++) begin
            runRow(rowNames[r], rows[r]);
        end
        checkErrorResponses();

        asrtFails = uut.uRegs.uApbChk.failCount;
        for (int l = 0; l < `DOM_LANES; l++) begin
            asrtFails += laneFails[l];
        end
        $display("Checks %0d, value and timeout errors %0d, assertion failures %0d",
                 mon.checkCount, mon.errCount, asrtFails);
        if (mon.errCount == 0 && asrtFails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/dom_pkg.sv
rtl/dom_apb_regs.sv
rtl/share_splitter.sv
rtl/dom_mul_gf4.sv
rtl/share_combiner.sv
rtl/dom_gf4_top.sv
sim/dom_gf4_checker.sv
sim/dom_gf4_monitor.sv
sim/dom_gf4_tb.sv

// ==== Bender.yml ====
package:
  name: dom_gf4

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dom_pkg.sv
      - rtl/dom_apb_regs.sv
      - rtl/share_splitter.sv
      - rtl/dom_mul_gf4.sv
      - rtl/share_combiner.sv
      - rtl/dom_gf4_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/dom_gf4_checker.sv
      - sim/dom_gf4_monitor.sv
      - sim/dom_gf4_tb.sv
